/* hdl/dma_pkg.sv */
// shared codes for the DMA engine
// register indexes match the bit order of the CPU write strobe vector
package dma_pkg;

    localparam int WORD_W   = 16;   // DRAM and IDE word
    localparam int BYTE_W   = 8;    // CPU and SD byte
    localparam int NUM_REGS = 9;    // width of the strobe vector

    // target device, low three bits of the control byte
    typedef enum logic [2:0] {
        DEV_NONE = 3'd0,
        DEV_RAM  = 3'd1,
        DEV_SD   = 3'd2,
        DEV_IDE  = 3'd3
    } dev_e;

    // strobe bit positions
    typedef enum logic [3:0] {
        REG_SADDR_L = 4'd0,
        REG_SADDR_H = 4'd1,
        REG_SADDR_X = 4'd2,
        REG_DADDR_L = 4'd3,
        REG_DADDR_H = 4'd4,
        REG_DADDR_X = 4'd5,
        REG_LEN     = 4'd6,
        REG_CTRL    = 4'd7,
        REG_NUM     = 4'd8
    } reg_e;

    // control byte fields
    localparam int CTRL_WNR    = 7;     // 1 moves RAM to device
    localparam int CTRL_ZWAIT  = 6;     // hold the CPU during transfer
    localparam int CTRL_SALGN  = 5;
    localparam int CTRL_DALGN  = 4;
    localparam int CTRL_SIZE   = 3;     // align step 512 instead of 256
    localparam int CTRL_DEV_HI = 2;
    localparam int CTRL_DEV_LO = 0;

endpackage

/* hdl/dma_regs.sv */
// CPU side register file, writes ignored while a transfer runs
// launch needs a refresh cycle seen since the previous transfer
`timescale 1ns/1ps

module dma_regs #(
    parameter int LEN_W = 8
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [dma_pkg::NUM_REGS-1:0]  reg_wr,
    input  logic [dma_pkg::BYTE_W-1:0]    zdata,
    input  logic                          rfsh_n,
    input  logic                          act,
    output logic                          launch,
    output logic                          wnr,
    output logic                          zwait,
    output logic                          src_align,
    output logic                          dst_align,
    output logic                          size,
    output dma_pkg::dev_e                 device,
    output logic [LEN_W-1:0]              len,
    output logic [LEN_W-1:0]              num,
    output logic                          src_load_l,
    output logic                          src_load_h,
    output logic                          src_load_x,
    output logic                          dst_load_l,
    output logic                          dst_load_h,
    output logic                          dst_load_x,
    output logic                          cpu_wait
);
    import dma_pkg::*;

    logic [NUM_REGS-1:0] wr;   // strobes after blocking
    logic                launch_en;

    assign wr         = reg_wr & {NUM_REGS{~act}};
    assign launch     = wr[REG_CTRL] & launch_en;
    assign src_load_l = wr[REG_SADDR_L];
    assign src_load_h = wr[REG_SADDR_H];
    assign src_load_x = wr[REG_SADDR_X];
    assign dst_load_l = wr[REG_DADDR_L];
    assign dst_load_h = wr[REG_DADDR_H];
    assign dst_load_x = wr[REG_DADDR_X];
    assign cpu_wait   = act & zwait;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            launch_en <= 1'b0;
            wnr       <= 1'b0;
            zwait     <= 1'b0;
            src_align <= 1'b0;
            dst_align <= 1'b0;
            size      <= 1'b0;
            device    <= DEV_NONE;
        end
        else
        begin
            // refresh during a transfer does not count
            if (act)
                launch_en <= 1'b0;
            else if (!rfsh_n)
                launch_en <= 1'b1;

            if (launch)
            begin
                wnr       <= zdata[CTRL_WNR];
                zwait     <= zdata[CTRL_ZWAIT];
                src_align <= zdata[CTRL_SALGN];
                dst_align <= zdata[CTRL_DALGN];
                size      <= zdata[CTRL_SIZE];
                device    <= dev_e'(zdata[CTRL_DEV_HI:CTRL_DEV_LO]);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr[REG_LEN])
            len <= zdata[LEN_W-1:0];    // cycles per burst minus one
        if (wr[REG_NUM])
            num <= zdata[LEN_W-1:0];    // bursts minus one
    end

    // sequencer must pick up every accepted launch on the next edge
    assert property (@(posedge clk) disable iff (!rst_n) launch |-> !act ##1 act)
        else $error("launch while active or act not raised after launch");

endmodule

/* hdl/dma_addr_gen.sv */
// word address counter, loaded from CPU bytes, low byte carries bits 7..1 only
// aligned bursts restart at the saved low byte and step 256 or 512 words
`timescale 1ns/1ps

module dma_addr_gen #(
    parameter int ADDR_W = 21
) (
    input  logic                        clk,
    input  logic [dma_pkg::BYTE_W-1:0]  zdata,
    input  logic                        load_l,
    input  logic                        load_h,
    input  logic                        load_x,
    input  logic                        align,
    input  logic                        size,
    input  logic                        step,
    input  logic                        next_burst,
    output logic [ADDR_W-1:0]           addr
);

    localparam int HI_W = ADDR_W - 8;   // bits above the restart byte

    logic [7:0]        saved_l;   // burst restart point
    logic [HI_W-1:0]   hi_step;
    logic [ADDR_W-1:0] addr_next;

    assign hi_step = size ? HI_W'(2) : HI_W'(1);

    always_comb
    begin
        if (align && next_burst)
            addr_next = {addr[ADDR_W-1:8] + hi_step, saved_l};
        else
            addr_next = addr + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        // byte address from the CPU, bit 0 dropped
        if (load_l)
        begin
            addr[6:0]    <= zdata[7:1];
            saved_l[6:0] <= zdata[7:1];
        end

        if (load_h)
        begin
            addr[12:7] <= zdata[5:0];
            saved_l[7] <= zdata[0];
        end

        if (load_x)
            addr[ADDR_W-1:13] <= zdata[ADDR_W-14:0];

        if (step)
            addr <= addr_next;   // one word per DRAM access
    end

    // loads are blocked while active and steps only happen while active
    assert property (@(posedge clk) !(step && (load_l || load_h || load_x)))
        else $error("address load during a running transfer");

endmodule

/* hdl/dma_sequencer.sv */
// read phase then write phase per word, (len+1) words per burst, (num+1) bursts
// RAM to RAM uses DRAM for both phases, source address on read
`timescale 1ns/1ps

module dma_sequencer #(
    parameter int ADDR_W = 21,
    parameter int LEN_W  = 8
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        launch,
    input  logic                        wnr,
    input  dma_pkg::dev_e               device,
    input  logic [LEN_W-1:0]            len,
    input  logic [LEN_W-1:0]            num,
    input  logic                        dram_next,
    input  logic                        dev_stb,
    input  logic [dma_pkg::WORD_W-1:0]  dram_rddata,
    input  logic [dma_pkg::WORD_W-1:0]  dev_rddata,
    input  logic [ADDR_W-1:0]           src_addr,
    input  logic [ADDR_W-1:0]           dst_addr,
    output logic                        act,
    output logic                        phase,
    output logic                        dev_req,
    output logic [dma_pkg::WORD_W-1:0]  data,
    output logic                        next_burst,
    output logic                        step_src,
    output logic                        step_dst,
    output logic [ADDR_W-1:0]           dram_addr,
    output logic                        dram_req,
    output logic                        dram_rnw
);
    import dma_pkg::*;

    logic [LEN_W-1:0] b_ctr;   // cycles left in burst
    logic [LEN_W:0]   n_ctr;   // bursts left, msb set when idle
    logic             is_ram;
    logic             state_mem;
    logic             state_dev;
    logic             mem_done;
    logic             phase_end;
    logic             cyc_end;

    assign act    = ~n_ctr[LEN_W];
    assign is_ram = (device == DEV_RAM);

    // device reads first when it feeds RAM
    assign state_dev = ~is_ram & (wnr ^ ~phase);
    assign state_mem = is_ram | (wnr ^ phase);

    assign dram_req  = act & state_mem;
    assign dev_req   = act & state_dev;
    assign dram_rnw  = ~phase;
    assign dram_addr = phase ? dst_addr : src_addr;

    assign mem_done   = dram_req & dram_next;
    assign phase_end  = mem_done | (dev_req & dev_stb);
    assign cyc_end    = phase & phase_end;
    assign next_burst = (b_ctr == '0);
    assign step_src   = mem_done & ~phase;
    assign step_dst   = mem_done & phase;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            phase <= 1'b0;
            b_ctr <= '0;
            n_ctr <= '1;   // idle
        end
        else if (launch)
        begin
            phase <= 1'b0;
            b_ctr <= len;
            n_ctr <= {1'b0, num};
        end
        else
        begin
            if (phase_end)
                phase <= ~phase;
            if (cyc_end)
            begin
                b_ctr <= next_burst ? len : b_ctr - 1'b1;
                n_ctr <= n_ctr - {{LEN_W{1'b0}}, next_burst};   // wraps to idle
            end
        end
    end

    // word buffer between the two phases
    always_ff @(posedge clk)
    begin
        if (!phase && mem_done)
            data <= dram_rddata;
        else if (!phase && dev_req && dev_stb)
            data <= dev_rddata;
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(dram_req && dev_req))
        else $error("DRAM and device requested together");

    // request and address held until the DRAM answers
    assert property (@(posedge clk) disable iff (!rst_n)
        dram_req && !dram_next |=> dram_req && $stable(dram_addr))
        else $error("DRAM request changed before dram_next");

endmodule

/* hdl/dma_dev_port.sv */
// routes the device request to SD or IDE
// SD moves a word as two bytes, low byte first
`timescale 1ns/1ps

module dma_dev_port (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        launch,
    input  dma_pkg::dev_e               device,
    input  logic                        dev_req,
    input  logic                        phase,
    input  logic [dma_pkg::WORD_W-1:0]  data,
    input  logic [dma_pkg::BYTE_W-1:0]  sd_rddata,
    input  logic                        sd_stb,
    input  logic [dma_pkg::WORD_W-1:0]  ide_rddata,
    input  logic                        ide_stb,
    output logic [dma_pkg::WORD_W-1:0]  dev_rddata,
    output logic                        dev_stb,
    output logic [dma_pkg::BYTE_W-1:0]  sd_wrdata,
    output logic                        sd_req,
    output logic                        sd_rnw,
    output logic [dma_pkg::WORD_W-1:0]  ide_wrdata,
    output logic                        ide_req,
    output logic                        ide_rnw
);
    import dma_pkg::*;

    logic              is_sd;
    logic              is_ide;
    logic              bsel;       // 0 low byte, 1 high byte
    logic              byte_stb;
    logic [BYTE_W-1:0] lo_byte;    // first SD byte of a word

    assign is_sd    = (device == DEV_SD);
    assign is_ide   = (device == DEV_IDE);
    assign byte_stb = is_sd & sd_req & sd_stb;

    assign sd_req    = dev_req & is_sd;
    assign sd_rnw    = ~phase;
    assign sd_wrdata = bsel ? data[WORD_W-1:BYTE_W] : data[BYTE_W-1:0];

    assign ide_req    = dev_req & is_ide;
    assign ide_rnw    = ~phase;
    assign ide_wrdata = data;

    // word complete on second SD byte
    assign dev_rddata = is_sd ? {sd_rddata, lo_byte} : ide_rddata;
    assign dev_stb    = (byte_stb & bsel) | (ide_req & ide_stb);

    always_ff @(posedge clk)
    begin
        if (!rst_n || launch)
            bsel <= 1'b0;
        else if (byte_stb)
            bsel <= ~bsel;
    end

    always_ff @(posedge clk)
    begin
        if (byte_stb && !bsel && !phase)
            lo_byte <= sd_rddata;
    end

    // every device phase ends on a word boundary
    assert property (@(posedge clk) disable iff (!rst_n) dev_stb |=> !bsel)
        else $error("SD byte select out of step after device phase");

endmodule

/* hdl/dma_top.sv */
// DMA engine top, 16-bit words between DRAM and DRAM, SD or IDE
// register strobes are one per register, see dma_pkg for the order
`timescale 1ns/1ps

module dma_top #(
    parameter int ADDR_W = 21,
    parameter int LEN_W  = 8
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [dma_pkg::NUM_REGS-1:0]  reg_wr,
    input  logic [dma_pkg::BYTE_W-1:0]    zdata,
    input  logic                          rfsh_n,
    output logic                          act,
    output logic                          cpu_wait,
    output logic [ADDR_W-1:0]             dram_addr,
    input  logic [dma_pkg::WORD_W-1:0]    dram_rddata,
    output logic [dma_pkg::WORD_W-1:0]    dram_wrdata,
    output logic                          dram_req,
    output logic                          dram_rnw,
    input  logic                          dram_next,
    input  logic [dma_pkg::BYTE_W-1:0]    sd_rddata,
    output logic [dma_pkg::BYTE_W-1:0]    sd_wrdata,
    output logic                          sd_req,
    output logic                          sd_rnw,
    input  logic                          sd_stb,
    input  logic [dma_pkg::WORD_W-1:0]    ide_rddata,
    output logic [dma_pkg::WORD_W-1:0]    ide_wrdata,
    output logic                          ide_req,
    output logic                          ide_rnw,
    input  logic                          ide_stb
);
    import dma_pkg::*;

    logic              launch;
    logic              wnr;
    logic              src_align;
    logic              dst_align;
    logic              size;
    dev_e              device;
    logic [LEN_W-1:0]  len;
    logic [LEN_W-1:0]  num;
    logic              src_load_l;
    logic              src_load_h;
    logic              src_load_x;
    logic              dst_load_l;
    logic              dst_load_h;
    logic              dst_load_x;
    logic              phase;
    logic              dev_req;
    logic              next_burst;
    logic              step_src;
    logic              step_dst;
    logic [ADDR_W-1:0] src_addr;
    logic [ADDR_W-1:0] dst_addr;
    logic [WORD_W-1:0] dev_rddata;
    logic              dev_stb;

    dma_regs #(.LEN_W(LEN_W)) u_regs (
        .clk(clk), .rst_n(rst_n), .reg_wr(reg_wr), .zdata(zdata), .rfsh_n(rfsh_n),
        .act(act), .launch(launch), .wnr(wnr), .zwait(),
        .src_align(src_align), .dst_align(dst_align), .size(size), .device(device),
        .len(len), .num(num),
        .src_load_l(src_load_l), .src_load_h(src_load_h), .src_load_x(src_load_x),
        .dst_load_l(dst_load_l), .dst_load_h(dst_load_h), .dst_load_x(dst_load_x),
        .cpu_wait(cpu_wait)
    );

    dma_addr_gen #(.ADDR_W(ADDR_W)) u_src (
        .clk(clk), .zdata(zdata),
        .load_l(src_load_l), .load_h(src_load_h), .load_x(src_load_x),
        .align(src_align), .size(size), .step(step_src), .next_burst(next_burst),
        .addr(src_addr)
    );

    dma_addr_gen #(.ADDR_W(ADDR_W)) u_dst (
        .clk(clk), .zdata(zdata),
        .load_l(dst_load_l), .load_h(dst_load_h), .load_x(dst_load_x),
        .align(dst_align), .size(size), .step(step_dst), .next_burst(next_burst),
        .addr(dst_addr)
    );

    dma_sequencer #(.ADDR_W(ADDR_W), .LEN_W(LEN_W)) u_seq (
        .clk(clk), .rst_n(rst_n), .launch(launch), .wnr(wnr), .device(device),
        .len(len), .num(num), .dram_next(dram_next), .dev_stb(dev_stb),
        .dram_rddata(dram_rddata), .dev_rddata(dev_rddata),
        .src_addr(src_addr), .dst_addr(dst_addr),
        .act(act), .phase(phase), .dev_req(dev_req), .data(dram_wrdata),
        .next_burst(next_burst), .step_src(step_src), .step_dst(step_dst),
        .dram_addr(dram_addr), .dram_req(dram_req), .dram_rnw(dram_rnw)
    );

    dma_dev_port u_dev (
        .clk(clk), .rst_n(rst_n), .launch(launch), .device(device),
        .dev_req(dev_req), .phase(phase), .data(dram_wrdata),
        .sd_rddata(sd_rddata), .sd_stb(sd_stb),
        .ide_rddata(ide_rddata), .ide_stb(ide_stb),
        .dev_rddata(dev_rddata), .dev_stb(dev_stb),
        .sd_wrdata(sd_wrdata), .sd_req(sd_req), .sd_rnw(sd_rnw),
        .ide_wrdata(ide_wrdata), .ide_req(ide_req), .ide_rnw(ide_rnw)
    );

endmodule

/* verification/dma_models.sv */
// DRAM, SD and IDE responders, each answers a request after 0 to 3 idle cycles
// unwritten DRAM words read as a pattern of the word address, SD and IDE sources count up
`timescale 1ns/1ps

module dma_models #(
    parameter int ADDR_W = 21
) (
    input  logic              clk,
    input  logic [ADDR_W-1:0] dram_addr,
    input  logic [15:0]       dram_wrdata,
    input  logic              dram_req,
    input  logic              dram_rnw,
    output logic [15:0]       dram_rddata,
    output logic              dram_next,
    input  logic [7:0]        sd_wrdata,
    input  logic              sd_req,
    input  logic              sd_rnw,
    output logic [7:0]        sd_rddata,
    output logic              sd_stb,
    input  logic [15:0]       ide_wrdata,
    input  logic              ide_req,
    input  logic              ide_rnw,
    output logic [15:0]       ide_rddata,
    output logic              ide_stb
);

    logic [15:0] mem [int];     // sparse DRAM, key is the word address
    logic [7:0]  sd_log [$];    // bytes written to SD in order
    logic [15:0] ide_log [$];
    int          seed = 32'h1aae_fbb1;
    int          dram_dly;
    int          sd_dly;
    int          ide_dly;
    int          sd_cnt;        // bytes read so far
    int          ide_cnt;

    function automatic logic [15:0] read_word(input logic [ADDR_W-1:0] a);
        if (mem.exists(int'(a)))
            return mem[int'(a)];
        return a[15:0] ^ 16'(a >> 5) ^ 16'hc3a5;
    endfunction

    function automatic int next_delay();
        return $random(seed) & 3;
    endfunction

    initial
    begin
        dram_rddata = '0;
        dram_next   = 1'b0;
        sd_rddata   = '0;
        sd_stb      = 1'b0;
        ide_rddata  = '0;
        ide_stb     = 1'b0;
    end

    // all responses change 1 ns after the edge
    always @(posedge clk)
    begin
        #1;
        if (dram_next)
        begin
            dram_next = 1'b0;
            dram_dly  = next_delay();
        end
        else if (dram_req && dram_dly > 0)
            dram_dly--;
        else if (dram_req)
        begin
            if (dram_rnw)
                dram_rddata = read_word(dram_addr);
            else
                mem[int'(dram_addr)] = dram_wrdata;
            dram_next = 1'b1;
        end
    end

    always @(posedge clk)
    begin
        #1;
        if (sd_stb)
        begin
            sd_stb = 1'b0;
            sd_dly = next_delay();
        end
        else if (sd_req && sd_dly > 0)
            sd_dly--;
        else if (sd_req)
        begin
            if (sd_rnw)
            begin
                sd_rddata = 8'(8'ha0 + sd_cnt);   // byte stream a0, a1, ...
                sd_cnt++;
            end
            else
                sd_log.push_back(sd_wrdata);
            sd_stb = 1'b1;
        end
    end

    always @(posedge clk)
    begin
        #1;
        if (ide_stb)
        begin
            ide_stb = 1'b0;
            ide_dly = next_delay();
        end
        else if (ide_req && ide_dly > 0)
            ide_dly--;
        else if (ide_req)
        begin
            if (ide_rnw)
            begin
                ide_rddata = 16'(16'he100 + ide_cnt);
                ide_cnt++;
            end
            else
                ide_log.push_back(ide_wrdata);
            ide_stb = 1'b1;
        end
    end

endmodule

/* verification/tb_dma.sv */
// trace driven testbench, run from the project root so the trace file is found
// every task starts and ends 1 ns after a rising edge
`timescale 1ns/1ps

module tb_dma;
    import dma_pkg::*;

    localparam int ADDR_W    = 21;
    localparam int TRACE_LEN = 128;
    localparam int TIMEOUT   = 1000;   // cycles per wait

    logic                clk;
    logic                rst_n;
    logic [NUM_REGS-1:0] reg_wr;
    logic [BYTE_W-1:0]   zdata;
    logic                rfsh_n;
    logic                act;
    logic                cpu_wait;
    logic [ADDR_W-1:0]   dram_addr;
    logic [WORD_W-1:0]   dram_rddata;
    logic [WORD_W-1:0]   dram_wrdata;
    logic                dram_req;
    logic                dram_rnw;
    logic                dram_next;
    logic [BYTE_W-1:0]   sd_rddata;
    logic [BYTE_W-1:0]   sd_wrdata;
    logic                sd_req;
    logic                sd_rnw;
    logic                sd_stb;
    logic [WORD_W-1:0]   ide_rddata;
    logic [WORD_W-1:0]   ide_wrdata;
    logic                ide_req;
    logic                ide_rnw;
    logic                ide_stb;
    logic [47:0]         trace [0:TRACE_LEN-1];   // op, count, arg, data

    dma_top #(.ADDR_W(ADDR_W), .LEN_W(8)) u_dut (.*);

    dma_models #(.ADDR_W(ADDR_W)) u_models (.*);

    always #4 clk = ~clk;

    task automatic fail_run();
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got === exp)
        else
        begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic write_reg(input int idx, input logic [7:0] value);
        reg_wr      = '0;
        reg_wr[idx] = 1'b1;
        zdata       = value;
        @(posedge clk);
        #1;
        reg_wr = '0;
    endtask

    // word address to the three CPU byte registers, byte bit 0 is zero
    task automatic set_addr(input int base, input logic [ADDR_W-1:0] a);
        write_reg(base, {a[6:0], 1'b0});
        write_reg(base + 1, {2'b00, a[12:7]});
        write_reg(base + 2, a[20:13]);
    endtask

    task automatic refresh_pulse();
        rfsh_n = 1'b0;
        @(posedge clk);
        #1;
        rfsh_n = 1'b1;
    endtask

    task automatic wait_idle(input logic zwait_exp);
        int cycles;
        cycles = 0;
        while (act && cycles < TIMEOUT)
        begin
            check_value("cpu_wait", 16'(cpu_wait), 16'(zwait_exp));
            @(posedge clk);
            #1;
            cycles++;
        end
        assert (!act)
        else
        begin
            $display("transfer still running after %0d cycles", TIMEOUT);
            fail_run();
        end
        check_value("cpu_wait", 16'(cpu_wait), 16'h0);   // released together with act
    endtask

    task automatic run_step(input logic [47:0] entry);
        logic [3:0]  op;
        int          n;
        int          a;
        logic [15:0] value;
        int          k;
        op    = entry[47:44];
        n     = int'(entry[43:40]);
        a     = int'(entry[39:16]);
        value = entry[15:0];
        case (op)
            4'h1:
                for (k = 0; k <= n; k++)
                    u_models.mem[a + k] = value + 16'(k);
            4'h2: write_reg(a, value[7:0]);
            4'h3: set_addr(REG_SADDR_L, ADDR_W'(a));
            4'h4: set_addr(REG_DADDR_L, ADDR_W'(a));
            4'h5: refresh_pulse();
            4'h6: wait_idle(value[0]);
            4'h7: check_value("act", 16'(act), value);
            4'h8:
                for (k = 0; k <= n; k++)
                    check_value($sformatf("dram[%06h]", a + k), u_models.mem[a + k],
                                value + 16'(k));
            4'h9:
                for (k = 0; k <= n; k++)
                    check_value($sformatf("sd_wrdata[%0d]", a + k),
                                16'(u_models.sd_log[a + k]), value + 16'(k));
            4'ha:
                for (k = 0; k <= n; k++)
                    check_value($sformatf("ide_wrdata[%0d]", a + k),
                                u_models.ide_log[a + k], value + 16'(k));
            default:
            begin
                $display("unknown trace command %h", op);
                fail_run();
            end
        endcase
    endtask

    initial
    begin
        int   i;
        logic done;
        clk    = 1'b0;
        rst_n  = 1'b0;
        reg_wr = '0;
        zdata  = '0;
        rfsh_n = 1'b1;
        $readmemh("verification/dma_trace.txt", trace);
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        check_value("act", 16'(act), 16'h0);
        check_value("cpu_wait", 16'(cpu_wait), 16'h0);
        check_value("dram_req", 16'(dram_req), 16'h0);
        check_value("sd_req", 16'(sd_req), 16'h0);
        check_value("ide_req", 16'(ide_req), 16'h0);

        i    = 0;
        done = 1'b0;
        while (!done && i < TRACE_LEN)
        begin
            if (trace[i][47:44] == 4'h0)
                done = 1'b1;   // end marker
            else
                run_step(trace[i]);
            i++;
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

/* verification/dma_trace.txt */
// fields are op, n, arg, data and a command covers n+1 items with data counting up
// op 1 preload dram, 2 write register arg, 3 source word address, 4 destination word address
// op 5 refresh, 6 wait idle with data as cpu_wait bit, 7 act, 8 dram, 9 sd byte, a ide word
// aligned RAM copy with bursts 256 words apart and an early launch
1_3_000100_1100
1_3_000200_1200
3_0_000100_0000
4_0_001000_0000
2_0_000006_0003
2_0_000008_0001
2_0_000007_0031   // no refresh seen yet
7_0_000000_0000
5_0_000000_0000
2_0_000007_0031
7_0_000000_0001
6_0_000000_0000
8_3_001000_1100
8_3_001100_1200
// source bursts 512 words apart with the CPU held
1_3_000410_2410
1_3_000610_2610
3_0_000410_0000
4_0_102000_0000
5_0_000000_0000
2_0_000007_0069
2_0_000006_0000   // blocked while active
2_0_000008_0000
2_0_000003_0040
6_0_000000_0001
8_3_102000_2410
8_3_102004_2610
// SD to RAM with length, count and destination carried over
5_0_000000_0000
2_0_000007_0002
6_0_000000_0000
8_0_102008_a1a0
8_0_102009_a3a2
8_0_10200a_a5a4
8_0_10200b_a7a6
8_0_10200c_a9a8
8_0_10200d_abaa
8_0_10200e_adac
8_0_10200f_afae
// RAM to SD, low byte first
1_1_003000_c35a
3_0_003000_0000
2_0_000006_0001
2_0_000008_0000
5_0_000000_0000
2_0_000007_0082
6_0_000000_0000
9_0_000000_005a
9_0_000001_00c3
9_0_000002_005b
9_0_000003_00c3
// IDE to RAM and back
4_0_004000_0000
3_0_004000_0000
2_0_000006_0003
5_0_000000_0000
2_0_000007_0003
6_0_000000_0000
8_3_004000_e100
5_0_000000_0000
2_0_000007_0083
6_0_000000_0000
a_3_000000_e100
0_0_000000_0000

/* compile.f */
hdl/dma_pkg.sv
hdl/dma_regs.sv
hdl/dma_addr_gen.sv
hdl/dma_sequencer.sv
hdl/dma_dev_port.sv
hdl/dma_top.sv
verification/dma_models.sv
verification/tb_dma.sv

/* Makefile */
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_dma
RTL_TOP    = dma_top
FILELIST   = compile.f
OBJ_DIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulation is the test result
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
